// ==== verilog/upd_timing_pkg.sv ====
// Machine-cycle timing definitions
`default_nettype none

package upd_timing_pkg;

  ////////////////////////////////////////////////////////////////////
  // machine cycle

  // position within one machine cycle
  typedef logic [2:0] phase_t;

  localparam int unsigned CYCLE_LEN = 8;   // enabled clocks per cycle

  ////////////////////////////////////////////////////////////////////
  // strobe slots

  localparam phase_t PHASE_PRELOAD = 3'd6; // cp2n slot
  localparam phase_t PHASE_LOAD    = 3'd7; // cp1p slot, last of cycle

endpackage

`default_nettype wire

// ==== verilog/upd_sound_pkg.sv ====
// Sound output definitions
`default_nettype none

package upd_sound_pkg;

  ////////////////////////////////////////////////////////////////////
  // data widths

  typedef logic [7:0]  tone_div_t;   // N reload value, NC count
  typedef logic [2:0]  tone_step_t;  // NUC reload count
  typedef logic [7:0]  sample_t;     // DAC magnitude
  typedef logic [8:0]  pcm_t;        // two's complement PCM
  typedef logic [11:0] int_vec_t;    // program address

  ////////////////////////////////////////////////////////////////////
  // tone interrupt

  typedef enum logic [1:0] {
    IRQ_IDLE    = 2'd0,
    IRQ_PENDING = 2'd1,
    IRQ_ACTIVE  = 2'd2
  } irq_state_e;

  localparam int_vec_t TONE_VEC_BASE = 12'h020; // N below 10h
  localparam int_vec_t TONE_VEC_R10  = 12'h004; // N 10h to 1Fh
  localparam int_vec_t TONE_VEC_R20  = 12'h008; // N 20h to 3Fh
  localparam int_vec_t TONE_VEC_R40  = 12'h00c; // N 40h and up

  ////////////////////////////////////////////////////////////////////
  // N range bounds

  // each bound is the lowest N of its range
  localparam tone_div_t N_R08 = 8'h08;
  localparam tone_div_t N_R10 = 8'h10;
  localparam tone_div_t N_R20 = 8'h20;
  localparam tone_div_t N_R40 = 8'h40;

endpackage

`default_nettype wire

// ==== verilog/phase_gen.sv ====
// Machine-cycle phase generator
`default_nettype none
`timescale 1ns/100ps

module phase_gen (
  input  wire  CLK,
  input  wire  reset,
  input  wire  clk_en,
  output logic load_stb,
  output logic preload_stb
);

  import upd_timing_pkg::*;

  phase_t phase;              // position in machine cycle

  //////////////////////////////////////////////////////////////////////
  // phase counter

  always_ff @(posedge CLK) begin
    if (reset) begin
      phase <= '0;
    end else if (clk_en) begin
      if (phase == phase_t'(CYCLE_LEN - 1)) begin
        phase <= '0;          // wrap at end of cycle
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // strobe decode

  // Both strobes are qualified by clk_en so that a stalled clock never
  // repeats a slot; downstream logic counts one pulse per cycle.
  always_comb begin
    preload_stb = clk_en & (phase == PHASE_PRELOAD);
    load_stb    = clk_en & (phase == PHASE_LOAD);
  end

endmodule

`default_nettype wire

// ==== verilog/tone_divider.sv ====
// Tone divider
`default_nettype none
`timescale 1ns/100ps

module tone_divider (
  input  wire                      CLK,
  input  wire                      reset,
  input  wire                      clk_en,
  input  wire                      load_stb,
  input  wire                      preload_stb,
  input  wire                      load_n,
  input  wire upd_sound_pkg::tone_div_t n_value,
  output logic                     tone_trig,
  output logic [1:0]               tone_range
);

  import upd_sound_pkg::*;

  tone_div_t  n;              // reload value
  tone_div_t  nc;             // down-counter
  tone_step_t nuc;            // counts NC reloads
  logic       nc_reload;
  logic       reload_d;       // reload, one cycle late
  logic [1:0] range_c;
  logic       silent_c;
  logic       silent_q;       // N below 08h, no tone
  logic       tone_cond;
  logic       tone_cond_d;

  //////////////////////////////////////////////////////////////////////
  // N register and counters

  always_ff @(posedge CLK) begin
    if (reset) begin
      n <= '0;
    end else if (clk_en && load_n) begin
      n <= n_value;           // immediate load
    end
  end

  assign nc_reload = (nc == 8'd1);

  always_ff @(posedge CLK) begin
    if (reset) begin
      nc       <= '0;
      nuc      <= '0;
      reload_d <= 1'b0;
    end else if (load_stb) begin
      reload_d <= nc_reload;
      if (nc_reload) begin
        nc <= n;
      end else begin
        nc <= nc - 1'b1;
      end
      if (reload_d) begin
        nuc <= nuc + 1'b1;    // step after each reload
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // range selection

  // 0 covers both 00h-07h and 08h-0Fh; silent splits the two
  always_comb begin
    range_c  = 2'd0;
    silent_c = 1'b0;
    if (n >= N_R40) begin
      range_c = 2'd3;
    end else if (n >= N_R20) begin
      range_c = 2'd2;         // 3Fh included
    end else if (n >= N_R10) begin
      range_c = 2'd1;
    end else if (n < N_R08) begin
      silent_c = 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      tone_range <= 2'd0;
      silent_q   <= 1'b1;
    end else if (preload_stb) begin
      tone_range <= range_c;  // settled ahead of load
      silent_q   <= silent_c;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tone condition and trigger

  always_comb begin
    case (tone_range)
      2'd0:    tone_cond = ~silent_q & nuc[2];
      2'd1:    tone_cond = nuc[1];
      2'd2:    tone_cond = nuc[0];
      default: tone_cond = reload_d;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      tone_cond_d <= 1'b0;
    end else if (load_stb) begin
      tone_cond_d <= tone_cond;
    end
  end

  // falling edge, seen on the load slot only
  assign tone_trig = load_stb & tone_cond_d & ~tone_cond;

endmodule

`default_nettype wire

// ==== verilog/tone_irq.sv ====
// Tone interrupt controller
`default_nettype none
`timescale 1ns/100ps

module tone_irq (
  input  wire                     CLK,
  input  wire                     reset,
  input  wire                     clk_en,
  input  wire                     load_stb,
  input  wire                     preload_stb,
  input  wire                     tone_trig,
  input  wire  [1:0]              tone_range,
  input  wire                     tone_ie,
  input  wire                     tone_ack,
  output logic                    tone_irq_req,
  output upd_sound_pkg::int_vec_t tone_vec
);

  import upd_sound_pkg::*;

  irq_state_e state;
  int_vec_t   vec_offset;
  int_vec_t   vec_next;       // staged vector

  //////////////////////////////////////////////////////////////////////
  // vector

  always_comb begin
    case (tone_range)
      2'd1:    vec_offset = TONE_VEC_R10;
      2'd2:    vec_offset = TONE_VEC_R20;
      2'd3:    vec_offset = TONE_VEC_R40;
      default: vec_offset = '0;
    endcase
  end

  // staged one clock before the load slot, when activation can happen
  always_ff @(posedge CLK) begin
    if (preload_stb) begin
      vec_next <= TONE_VEC_BASE + vec_offset;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // state machine

  always_ff @(posedge CLK) begin
    if (reset) begin
      state    <= IRQ_IDLE;
      tone_vec <= '0;
    end else if (clk_en) begin
      case (state)
        IRQ_IDLE: begin
          if (tone_trig && tone_ie) begin
            state <= IRQ_PENDING;
          end
        end
        IRQ_PENDING: begin
          if (load_stb) begin
            state    <= IRQ_ACTIVE;
            tone_vec <= vec_next;   // held while active
          end
        end
        IRQ_ACTIVE: begin
          if (tone_ack) begin
            state <= IRQ_IDLE;      // RETI
          end
        end
        default: state <= IRQ_IDLE;
      endcase
    end
  end

  assign tone_irq_req = (state == IRQ_ACTIVE);

endmodule

`default_nettype wire

// ==== verilog/dac_output.sv ====
// DAC sample register
`default_nettype none
`timescale 1ns/100ps

module dac_output (
  input  wire                    CLK,
  input  wire                    reset,
  input  wire                    clk_en,
  input  wire                    da_write,
  input  wire upd_sound_pkg::sample_t sample,
  input  wire                    mix_sign,
  input  wire                    tone_sign,
  output upd_sound_pkg::pcm_t    pcm_out
);

  import upd_sound_pkg::*;

  logic [9:0] da;             // invert, sign, sample
  sample_t    mag;            // after inversion

  //////////////////////////////////////////////////////////////////////
  // DA register

  always_ff @(posedge CLK) begin
    if (reset) begin
      da <= '0;
    end else if (clk_en && da_write) begin
      da <= {mix_sign ^ tone_sign, mix_sign, sample};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // PCM formatting

  // da[9] inverts the sample into the DAC; a set sign bit then turns
  // the result into its one's complement for the 9-bit output
  always_comb begin
    mag     = da[9] ? ~da[7:0] : da[7:0];
    pcm_out = {da[8], (da[8] ? ~mag : mag)};
  end

endmodule

`default_nettype wire

// ==== verilog/upd1771c_sound.sv ====
// uPD1771C sound output
`default_nettype none
`timescale 1ns/100ps

module upd1771c_sound (
  input  wire                      CLK,
  input  wire                      reset,
  input  wire                      clk_en,
  input  wire                      load_n,
  input  wire upd_sound_pkg::tone_div_t n_value,
  input  wire                      tone_ie,
  input  wire                      tone_ack,
  input  wire                      da_write,
  input  wire upd_sound_pkg::sample_t   sample,
  input  wire                      mix_sign,
  input  wire                      tone_sign,
  output logic                     tone_irq_req,
  output upd_sound_pkg::int_vec_t  tone_vec,
  output upd_sound_pkg::pcm_t      pcm_out
);

  import upd_sound_pkg::*;

  logic       load_stb;       // cp1p
  logic       preload_stb;    // cp2n
  logic       tone_trig;
  logic [1:0] tone_range;     // vector offset code

  //////////////////////////////////////////////////////////////////////
  // timing and tone path

  phase_gen u_phase_gen (
    .CLK         (CLK),
    .reset       (reset),
    .clk_en      (clk_en),
    .load_stb    (load_stb),
    .preload_stb (preload_stb)
  );

  tone_divider u_tone_divider (
    .CLK         (CLK),
    .reset       (reset),
    .clk_en      (clk_en),
    .load_stb    (load_stb),
    .preload_stb (preload_stb),
    .load_n      (load_n),
    .n_value     (n_value),
    .tone_trig   (tone_trig),
    .tone_range  (tone_range)
  );

  tone_irq u_tone_irq (
    .CLK          (CLK),
    .reset        (reset),
    .clk_en       (clk_en),
    .load_stb     (load_stb),
    .preload_stb  (preload_stb),
    .tone_trig    (tone_trig),
    .tone_range   (tone_range),
    .tone_ie      (tone_ie),
    .tone_ack     (tone_ack),
    .tone_irq_req (tone_irq_req),
    .tone_vec     (tone_vec)
  );

  //////////////////////////////////////////////////////////////////////
  // DAC

  dac_output u_dac_output (
    .CLK       (CLK),
    .reset     (reset),
    .clk_en    (clk_en),
    .da_write  (da_write),
    .sample    (sample),
    .mix_sign  (mix_sign),
    .tone_sign (tone_sign),
    .pcm_out   (pcm_out)
  );

endmodule

`default_nettype wire

// ==== verification/tb_upd1771c_sound.sv ====
// uPD1771C sound output testbench
`default_nettype none
`timescale 1ns/100ps

module tb_upd1771c_sound;

  import upd_sound_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int CYCLE      = 8;      // enabled clocks per machine cycle
  localparam int REQ_WAIT   = 12000;  // clocks allowed for one request
  localparam int QUIET_WAIT = 3000;   // clocks watched for no request
  localparam int NUM_ROWS   = 7;
  localparam int NUM_DAC    = 16;

  typedef struct packed {
    tone_div_t n;
    logic      ie;
    int        period;                // clocks between requests, 0 for none
    int_vec_t  vec;
  } stim_row_t;

  localparam stim_row_t ROWS [NUM_ROWS] = '{
    '{8'h40, 1'b1, 512,  12'h02c},    // N * 8
    '{8'h9a, 1'b1, 1232, 12'h02c},
    '{8'h30, 1'b1, 768,  12'h028},    // 2 * N * 8
    '{8'h18, 1'b1, 768,  12'h024},    // 4 * N * 8
    '{8'h0c, 1'b1, 768,  12'h020},    // 8 * N * 8
    '{8'h05, 1'b1, 0,    12'h000},    // silent range
    '{8'h40, 1'b0, 0,    12'h000}     // interrupt disabled
  };

  logic      CLK;
  logic      reset;
  logic      clk_en;
  logic      load_n;
  tone_div_t n_value;
  logic      tone_ie;
  logic      tone_ack;
  logic      da_write;
  sample_t   sample;
  logic      mix_sign;
  logic      tone_sign;
  logic      tone_irq_req;
  int_vec_t  tone_vec;
  pcm_t      pcm_out;

  integer seed;
  int     errors;
  int     checks;
  int     tests;
  int     test_errors;

  upd1771c_sound dut (
    .CLK          (CLK),
    .reset        (reset),
    .clk_en       (clk_en),
    .load_n       (load_n),
    .n_value      (n_value),
    .tone_ie      (tone_ie),
    .tone_ack     (tone_ack),
    .da_write     (da_write),
    .sample       (sample),
    .mix_sign     (mix_sign),
    .tone_sign    (tone_sign),
    .tone_irq_req (tone_irq_req),
    .tone_vec     (tone_vec),
    .pcm_out      (pcm_out)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // compare and report

  task automatic note_failure(input string msg);
    errors++;
    test_errors++;
    $display("%s", msg);
  endtask

  task automatic check_vec(input string what, input int_vec_t exp, input int_vec_t got);
    checks++;
    if (got !== exp) begin
      note_failure($sformatf("ERROR %0t: %s vector expected %03h got %03h",
                             $time, what, exp, got));
    end
  endtask

  task automatic check_pcm(input string what, input pcm_t exp, input pcm_t got);
    checks++;
    if (got !== exp) begin
      note_failure($sformatf("ERROR %0t: %s pcm expected %03h got %03h",
                             $time, what, exp, got));
    end
  endtask

  task automatic check_period(input string what, input int exp, input int got);
    checks++;
    if (got != exp) begin
      note_failure($sformatf("ERROR %0t: %s period expected %0d got %0d clocks",
                             $time, what, exp, got));
    end
  endtask

  task automatic check_req(input string what, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      note_failure($sformatf("ERROR %0t: %s request expected %0b got %0b",
                             $time, what, exp, got));
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %s: %s", name, (test_errors == 0) ? "ok" : "failed");
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers

  task automatic wait_request(input int limit, output logic seen, output time t_seen);
    seen   = 1'b0;
    t_seen = 0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(posedge CLK);
      if (tone_irq_req) begin
        seen   = 1'b1;
        t_seen = $time;
      end
    end
  endtask

  task automatic ack_request();
    tone_ack <= 1'b1;                 // one-clock strobe
    @(posedge CLK);
    tone_ack <= 1'b0;
  endtask

  task automatic load_setting(input tone_div_t n, input logic ie);
    @(posedge CLK);
    n_value <= n;
    tone_ie <= ie;
    load_n  <= 1'b1;
    @(posedge CLK);
    load_n  <= 1'b0;
    repeat (3 * CYCLE) @(posedge CLK);  // let a range change settle
    if (tone_irq_req) begin
      ack_request();
    end
  endtask

  task automatic run_row(input stim_row_t row);
    logic  seen;
    logic  all_seen;
    time   t_rise [3];
    time   t_quiet;
    string name;
    name     = $sformatf("tone n=%02h ie=%0b", row.n, row.ie);
    all_seen = 1'b1;
    load_setting(row.n, row.ie);
    if (row.period == 0) begin
      wait_request(QUIET_WAIT, seen, t_quiet);
      if (seen) begin
        note_failure($sformatf("unexpected tone request for %s", name));
        ack_request();
      end
    end else begin
      // first two rises may follow the old N, the third interval does not
      for (int k = 0; k < 3 && all_seen; k++) begin
        wait_request(REQ_WAIT, seen, t_rise[k]);
        if (!seen) begin
          note_failure($sformatf("timeout: no tone request for %s", name));
          all_seen = 1'b0;
        end else begin
          if (k == 2) begin
            check_vec(name, row.vec, tone_vec);
          end
          ack_request();
        end
      end
      if (all_seen) begin
        check_period(name, row.period, int'(t_rise[2] - t_rise[1]) / CLK_PERIOD);
      end
    end
    finish_test(name);
  endtask

  //////////////////////////////////////////////////////////////////////
  // DAC and acknowledge tests

  task automatic run_dac();
    sample_t s;
    logic    ms;
    logic    ts;
    pcm_t    exp;
    for (int i = 0; i < NUM_DAC; i++) begin
      s  = sample_t'($random(seed));
      ms = i[0];
      ts = i[1];
      @(posedge CLK);
      sample    <= s;
      mix_sign  <= ms;
      tone_sign <= ts;
      da_write  <= 1'b1;
      @(posedge CLK);
      da_write  <= 1'b0;
      @(negedge CLK);
      exp = {ms, ts ? ~s : s};        // sign, then magnitude
      check_pcm($sformatf("dac sample %02h", s), exp, pcm_out);
    end
    @(posedge CLK);
    clk_en   <= 1'b0;
    da_write <= 1'b1;
    sample   <= ~sample;
    mix_sign <= ~mix_sign;
    repeat (2) @(posedge CLK);
    clk_en   <= 1'b1;
    da_write <= 1'b0;
    @(negedge CLK);
    check_pcm("dac write with clk_en low", exp, pcm_out);
    finish_test("dac formatting");
  endtask

  task automatic run_enable_ack();
    logic seen;
    logic held;
    time  t_seen;
    held = 1'b1;
    load_setting(8'h40, 1'b1);
    wait_request(REQ_WAIT, seen, t_seen);
    if (!seen) begin
      note_failure("timeout: no tone request for the acknowledge test");
    end else begin
      repeat (3 * 512) begin          // several trigger periods, no ack
        @(posedge CLK);
        if (!tone_irq_req) begin
          held = 1'b0;
        end
      end
      check_req("held without ack", 1'b1, held);
      ack_request();
      @(negedge CLK);
      check_req("after ack", 1'b0, tone_irq_req);
    end
    finish_test("enable and acknowledge");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    $timeformat(-9, 0, " ns", 0);
    seed        = 32'ha2e22bd8;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_errors = 0;
    reset     <= 1'b1;
    clk_en    <= 1'b1;
    load_n    <= 1'b0;
    n_value   <= '0;
    tone_ie   <= 1'b0;
    tone_ack  <= 1'b0;
    da_write  <= 1'b0;
    sample    <= '0;
    mix_sign  <= 1'b0;
    tone_sign <= 1'b0;
    repeat (10) @(posedge CLK);
    reset <= 1'b0;
    @(negedge CLK);
    check_req("reset", 1'b0, tone_irq_req);
    check_vec("reset", 12'h000, tone_vec);
    check_pcm("reset", 9'h000, pcm_out);
    finish_test("reset state");
    run_dac();
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(ROWS[r]);
    end
    run_enable_ack();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/upd_timing_pkg.sv
verilog/upd_sound_pkg.sv
verilog/phase_gen.sv
verilog/tone_divider.sv
verilog/tone_irq.sv
verilog/dac_output.sv
verilog/upd1771c_sound.sv
verification/tb_upd1771c_sound.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the uPD1771C sound testbench

rm -rf obj_dir

verilator --binary --timing --top-module tb_upd1771c_sound -f sources.f \
  -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "=== FAIL ===" sim.log \
  && { echo "simulation reported failure, see sim.log"; exit 1; } \
  || { echo "simulation finished without failure"; exit 0; }
